/* decode_defs.svh */
//////////////////////////////////////////////////
// Widths and RV32I major opcodes of the decode
// stage. Included by the package and by every
// RTL file that uses a width or an opcode
//////////////////////////////////////////////////

`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define XLEN              32          // Data and PC width
`define REG_AW            5           // Register bank address width

// Major opcodes, bits 6:0
`define OPC_LUI           7'b0110111
`define OPC_AUIPC         7'b0010111
`define OPC_JAL           7'b1101111
`define OPC_JALR          7'b1100111
`define OPC_BRANCH        7'b1100011
`define OPC_LOAD          7'b0000011
`define OPC_STORE         7'b0100011
`define OPC_OP_IMM        7'b0010011
`define OPC_OP            7'b0110011
`define OPC_MISC_MEM      7'b0001111

`define INSTR_ALIGN_BITS  2           // PC low bits zero on an aligned fetch

`endif

/* decode_pkg.sv */
//////////////////////////////////////////////////
// Types shared by the decode stage modules
// Widths come from the defines header
//////////////////////////////////////////////////

`include "decode_defs.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]   word_t;      // Instruction, data or PC
    typedef logic [`REG_AW-1:0] reg_addr_t;  // Register bank address

    // Operation handed on to execute
    typedef enum logic [4:0] {
        NOP,
        LUI,
        ADD, SUB,                            // AUIPC also maps to ADD
        SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        INVALID                              // Raises the illegal flag
    } op_e;

    // Instruction format, picks immediate and operand placement
    typedef enum logic [2:0] {
        R_FMT,
        I_FMT,
        S_FMT,
        B_FMT,
        U_FMT,
        J_FMT
    } format_e;

endpackage

/* dec_info_if.sv */
//////////////////////////////////////////////////
// Decoded instruction info, from the decoder to
// the lock control and the operand datapath
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface dec_info_if;
    import decode_pkg::*;

    op_e       op;        // Decoded operation
    format_e   fmt;       // Instruction format
    logic      use_rs1;   // Reads rs1
    logic      use_rs2;   // Reads rs2
    logic      is_load;
    logic      is_store;
    reg_addr_t rd;        // Destination, bits 11:7

    // Decoder side
    modport producer (output op, fmt, use_rs1, use_rs2, is_load, is_store, rd);

    // Register lock only needs the use flags and destination
    modport lock (input use_rs1, use_rs2, is_load, is_store, rd);

    // Immediate and operand selection
    modport datapath (input op, fmt);

endinterface

/* op_decoder.sv */
//////////////////////////////////////////////////
// RV32I opcode decoder. Turns opcode, funct3 and
// funct7 into an operation and a format, plus the
// register use flags for the hazard lock
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "decode_defs.svh"

module op_decoder (
    input  logic               clk,
    input  logic               reset,
    input  decode_pkg::word_t  instr_i,
    dec_info_if.producer       info
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    //////////////////////////////////////////////////
    // Operation
    //////////////////////////////////////////////////

    always_comb begin
        info.op = INVALID;                      // Anything not matched below
        case (opcode)
            `OPC_LUI:      info.op = LUI;
            `OPC_AUIPC:    info.op = ADD;       // PC + imm in execute
            `OPC_JAL:      info.op = JAL;
            `OPC_JALR:     info.op = JALR;
            `OPC_BRANCH: begin
                case (funct3)
                    3'b000:  info.op = BEQ;
                    3'b001:  info.op = BNE;
                    3'b100:  info.op = BLT;
                    3'b101:  info.op = BGE;
                    3'b110:  info.op = BLTU;
                    3'b111:  info.op = BGEU;
                    default: info.op = INVALID;
                endcase
            end
            `OPC_LOAD: begin
                case (funct3)
                    3'b000:  info.op = LB;
                    3'b001:  info.op = LH;
                    3'b010:  info.op = LW;
                    3'b100:  info.op = LBU;
                    3'b101:  info.op = LHU;
                    default: info.op = INVALID;
                endcase
            end
            `OPC_STORE: begin
                case (funct3)
                    3'b000:  info.op = SB;
                    3'b001:  info.op = SH;
                    3'b010:  info.op = SW;
                    default: info.op = INVALID;
                endcase
            end
            `OPC_OP_IMM: begin
                // funct7 only matters for the shifts
                case (funct3)
                    3'b000:  info.op = ADD;
                    3'b001:  info.op = (funct7 == 7'b0000000) ? SLL : INVALID;
                    3'b010:  info.op = SLT;
                    3'b011:  info.op = SLTU;
                    3'b100:  info.op = XOR;
                    3'b101:  info.op = (funct7 == 7'b0000000) ? SRL :
                                       (funct7 == 7'b0100000) ? SRA : INVALID;
                    3'b110:  info.op = OR;
                    default: info.op = AND;
                endcase
            end
            `OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: info.op = ADD;
                    10'b0100000_000: info.op = SUB;
                    10'b0000000_001: info.op = SLL;
                    10'b0000000_010: info.op = SLT;
                    10'b0000000_011: info.op = SLTU;
                    10'b0000000_100: info.op = XOR;
                    10'b0000000_101: info.op = SRL;
                    10'b0100000_101: info.op = SRA;
                    10'b0000000_110: info.op = OR;
                    10'b0000000_111: info.op = AND;
                    default:         info.op = INVALID;
                endcase
            end
            `OPC_MISC_MEM: info.op = (funct3 == 3'b000) ? NOP : INVALID;  // FENCE is a no-op
            default:       info.op = INVALID;   // SYSTEM included
        endcase
    end

    //////////////////////////////////////////////////
    // Format and register use
    //////////////////////////////////////////////////

    // Only bits 6:2 select, low bits forced to 11
    always_comb begin
        case ({opcode[6:2], 2'b11})
            `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: info.fmt = I_FMT;
            `OPC_STORE:                        info.fmt = S_FMT;
            `OPC_BRANCH:                       info.fmt = B_FMT;
            `OPC_LUI, `OPC_AUIPC:              info.fmt = U_FMT;
            `OPC_JAL:                          info.fmt = J_FMT;
            default:                           info.fmt = R_FMT;  // OP, FENCE, unknown
        endcase
    end

    assign info.use_rs1  = (info.fmt != U_FMT) && (info.fmt != J_FMT);
    assign info.use_rs2  = (info.fmt == R_FMT) || (info.fmt == S_FMT) || (info.fmt == B_FMT);
    assign info.is_load  = (opcode == `OPC_LOAD);
    assign info.is_store = (opcode == `OPC_STORE);
    assign info.rd       = instr_i[11:7];

    // Lock control and operand muxes both depend on a resolved format
    a_fmt_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(info.fmt));

endmodule

/* imm_gen.sv */
//////////////////////////////////////////////////
// Immediate generator. Builds every RV32I form and
// picks one by the decoded format
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "decode_defs.svh"

module imm_gen (
    input  decode_pkg::word_t  instr_i,
    dec_info_if.datapath       info,
    output decode_pkg::word_t  imm_o
);
    import decode_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // Sign always from bit 31
    assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};                   // Upper 20 bits
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        case (info.fmt)
            I_FMT:   imm_o = imm_i;
            S_FMT:   imm_o = imm_s;
            B_FMT:   imm_o = imm_b;
            U_FMT:   imm_o = imm_u;
            J_FMT:   imm_o = imm_j;
            default: imm_o = '0;   // R format has none
        endcase
    end

endmodule

/* hazard_ctrl.sv */
//////////////////////////////////////////////////
// Hazard control. Holds the replay register and
// the one-entry register lock, raises the bubble
// request on RAW and store-then-load hazards
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "decode_defs.svh"

module hazard_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall_i,
    input  decode_pkg::word_t      instr_i,
    dec_info_if.lock               info,
    output decode_pkg::word_t      instr_o,
    output decode_pkg::reg_addr_t  rs1_o,
    output decode_pkg::reg_addr_t  rs2_o,
    output decode_pkg::reg_addr_t  rd_o,
    output logic                   hazard_o
);
    import decode_pkg::*;

    word_t     last_instr;     // Instruction decoded last cycle
    logic      last_hazard;    // Last cycle issued a bubble
    reg_addr_t locked_reg;     // Destination still in flight
    logic      locked_store;   // Store still in flight
    reg_addr_t target_reg;
    logic      target_store;
    logic      hazard_rs1;
    logic      hazard_rs2;
    logic      hazard_mem;

    //////////////////////////////////////////////////
    // Replay
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        last_instr <= instr_o;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hazard <= 1'b0;   // First instruction from fetch
        end else begin
            last_hazard <= hazard_o;
        end
    end

    // Re-decode the held word after a bubble
    assign instr_o = last_hazard ? last_instr : instr_i;
    assign rs1_o   = instr_o[19:15];   // Straight to the register bank
    assign rs2_o   = instr_o[24:20];

    //////////////////////////////////////////////////
    // Register lock
    //////////////////////////////////////////////////

    assign hazard_rs1 = info.use_rs1 && (rs1_o != '0) && (locked_reg == rs1_o);
    assign hazard_rs2 = info.use_rs2 && (rs2_o != '0) && (locked_reg == rs2_o);
    assign hazard_mem = info.is_load && locked_store;   // Load right behind a store
    assign hazard_o   = hazard_rs1 || hazard_rs2 || hazard_mem;

    // Bubble locks nothing, so the replay goes through
    assign target_reg   = hazard_o ? '0 : info.rd;
    assign target_store = hazard_o ? 1'b0 : info.is_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked_reg   <= '0;
            locked_store <= 1'b0;
            rd_o         <= '0;
        end else if (hazard_o || !stall_i) begin   // Hazard wins over stall
            rd_o         <= locked_reg;            // Lines up with execute result
            locked_reg   <= target_reg;
            locked_store <= target_store;
        end
    end

    // Replay after a bubble must always issue
    a_single_bubble: assert property (@(posedge clk) disable iff (reset)
        hazard_o |=> !hazard_o);

endmodule

/* operand_stage.sv */
//////////////////////////////////////////////////
// Operand selection and the registered outputs of
// the decode stage, with the exception flags
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "decode_defs.svh"

module operand_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall_i,
    input  logic               hazard_i,
    dec_info_if.datapath       info,
    input  decode_pkg::word_t  instr_i,
    input  decode_pkg::word_t  pc_i,
    input  decode_pkg::word_t  imm_i,
    input  decode_pkg::word_t  rs1_data_i,
    input  decode_pkg::word_t  rs2_data_i,
    output decode_pkg::op_e    op_o,
    output decode_pkg::word_t  op1_o,
    output decode_pkg::word_t  op2_o,
    output decode_pkg::word_t  op3_o,
    output decode_pkg::word_t  pc_o,
    output logic               exc_illegal_o,
    output logic               exc_misaligned_o
);
    import decode_pkg::*;

    word_t op1;
    word_t op2;
    word_t op3;
    logic  illegal;
    logic  misaligned;

    always_comb begin
        case (info.fmt)
            U_FMT, J_FMT: begin   // Link or PC-relative
                op1 = pc_i;
                op2 = imm_i;
                op3 = imm_i;
            end
            R_FMT, B_FMT: begin   // Branch offset rides in op3
                op1 = rs1_data_i;
                op2 = rs2_data_i;
                op3 = imm_i;
            end
            S_FMT: begin          // Store data in op3
                op1 = rs1_data_i;
                op2 = imm_i;
                op3 = rs2_data_i;
            end
            default: begin        // I format
                op1 = rs1_data_i;
                op2 = imm_i;
                op3 = imm_i;
            end
        endcase
    end

    // Compressed quadrants are not supported
    assign illegal    = (info.op == INVALID) || (instr_i[1:0] != 2'b11);
    assign misaligned = pc_i[`INSTR_ALIGN_BITS-1:0] != '0;

    always_ff @(posedge clk) begin
        if (reset || hazard_i) begin   // Bubble looks like reset
            op_o             <= NOP;
            op1_o            <= '0;
            op2_o            <= '0;
            op3_o            <= '0;
            pc_o             <= '0;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (!stall_i) begin
            op_o             <= info.op;
            op1_o            <= op1;
            op2_o            <= op2;
            op3_o            <= op3;
            pc_o             <= pc_i;
            exc_illegal_o    <= illegal;
            exc_misaligned_o <= misaligned;
        end
    end

    // Execute never sees the instruction that hit the hazard
    a_bubble_nop: assert property (@(posedge clk) disable iff (reset)
        hazard_i |=> (op_o == NOP));

endmodule

/* decode_stage.sv */
//////////////////////////////////////////////////
// Decode stage top level of the RV32I core. Sits
// between fetch and execute, reads the register
// bank and issues bubbles on hazards
//////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage (
    input  logic         clk,
    input  logic         reset,
    input  logic         stall_i,
    input  logic [31:0]  instr_i,
    input  logic [31:0]  pc_i,
    input  logic [31:0]  rs1_data_i,
    input  logic [31:0]  rs2_data_i,
    output logic [4:0]   rs1_o,        // Register bank read ports
    output logic [4:0]   rs2_o,
    output logic [4:0]   rd_o,         // One cycle behind op_o
    output logic [4:0]   op_o,         // op_e encoding
    output logic [31:0]  op1_o,
    output logic [31:0]  op2_o,
    output logic [31:0]  op3_o,
    output logic [31:0]  pc_o,
    output logic         hazard_o,     // Bubble request to fetch
    output logic         exc_illegal_o,
    output logic         exc_misaligned_o
);
    import decode_pkg::*;

    word_t instr;   // Fetch word or replayed word
    word_t imm;

    dec_info_if info ();

    hazard_ctrl i_hazard_ctrl (
        .clk      (clk),
        .reset    (reset),
        .stall_i  (stall_i),
        .instr_i  (instr_i),
        .info     (info.lock),
        .instr_o  (instr),
        .rs1_o    (rs1_o),
        .rs2_o    (rs2_o),
        .rd_o     (rd_o),
        .hazard_o (hazard_o)
    );

    op_decoder i_op_decoder (
        .clk     (clk),
        .reset   (reset),
        .instr_i (instr),
        .info    (info.producer)
    );

    imm_gen i_imm_gen (
        .instr_i (instr),
        .info    (info.datapath),
        .imm_o   (imm)
    );

    operand_stage i_operand_stage (
        .clk              (clk),
        .reset            (reset),
        .stall_i          (stall_i),
        .hazard_i         (hazard_o),
        .info             (info.datapath),
        .instr_i          (instr),
        .pc_i             (pc_i),
        .imm_i            (imm),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .op_o             (op_o),
        .op1_o            (op1_o),
        .op2_o            (op2_o),
        .op3_o            (op3_o),
        .pc_o             (pc_o),
        .exc_illegal_o    (exc_illegal_o),
        .exc_misaligned_o (exc_misaligned_o)
    );

endmodule

/* tb_decode_stage.sv */
//////////////////////////////////////////////////
// Testbench for the RV32I decode stage. Builds a
// table of instruction rows, applies one per cycle
// and checks hazard, operands, flags and rd_o
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    localparam int PERIOD       = 20;   // ns
    localparam int RESET_CYCLES = 8;
    localparam int SEED         = 18;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Operand placement by format
    typedef enum {PL_PC, PL_RR, PL_ST, PL_RI} place_e;

    typedef struct packed {
        logic [31:0] fetch;      // Word on instr_i
        logic [31:0] instr;      // Word the stage decodes
        logic [31:0] pc;
        logic        stall;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        op_e         op;
        place_e      place;
        logic [31:0] imm;
        logic        hazard;
        logic        illegal;
        logic        misaligned;
    } row_t;

    logic        clk;
    logic        reset;
    logic        stall;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [4:0]  op;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] op3;
    logic [31:0] pc_out;
    logic        hazard;
    logic        exc_illegal;
    logic        exc_misaligned;

    row_t        rows[$];
    logic        built = 1'b0;
    int          cur_row = -1;    // -1 while checking reset state

    // Expected registered outputs
    op_e         exp_op;
    logic [31:0] exp_op1;
    logic [31:0] exp_op2;
    logic [31:0] exp_op3;
    logic [31:0] exp_pc;
    logic        exp_ill;
    logic        exp_mis;
    logic [4:0]  exp_rd;
    logic [4:0]  lock_rd;         // Destination still in flight

    decode_stage i_decode_stage (
        .clk(clk), .reset(reset), .stall_i(stall),
        .instr_i(instr), .pc_i(pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .op_o(op),
        .op1_o(op1), .op2_o(op2), .op3_o(op3), .pc_o(pc_out),
        .hazard_o(hazard), .exc_illegal_o(exc_illegal), .exc_misaligned_o(exc_misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Instruction encoders, RV32I field layout
    //////////////////////////////////////////////////

    function automatic logic [31:0] r_type(int f7, int rs2_a, int rs1_a, int f3, int rd_a);
        return {f7[6:0], rs2_a[4:0], rs1_a[4:0], f3[2:0], rd_a[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(int imm, int rs1_a, int f3, int rd_a,
                                           logic [6:0] opc);
        return {imm[11:0], rs1_a[4:0], f3[2:0], rd_a[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(int imm, int rs2_a, int rs1_a, int f3);
        return {imm[11:5], rs2_a[4:0], rs1_a[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(int imm, int rs2_a, int rs1_a, int f3);
        return {imm[12], imm[10:5], rs2_a[4:0], rs1_a[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(int imm20, int rd_a, logic [6:0] opc);
        return {imm20[19:0], rd_a[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(int imm, int rd_a);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd_a[4:0], 7'b1101111};
    endfunction

    //////////////////////////////////////////////////
    // Table
    //////////////////////////////////////////////////

    task automatic add_row(input logic [31:0] word, input logic [31:0] addr, input logic stl,
                           input op_e exp, input place_e place, input int imm,
                           input logic haz, input logic ill);
        row_t r;
        r.fetch      = word;
        r.instr      = word;
        r.pc         = addr;
        r.stall      = stl;
        r.rs1_data   = $urandom;
        r.rs2_data   = $urandom;
        r.op         = exp;
        r.place      = place;
        r.imm        = imm;
        r.hazard     = haz;
        r.illegal    = ill;
        r.misaligned = (addr[1:0] != 2'b00);   // Word aligned fetch only
        rows.push_back(r);
    endtask

    // Cycle after a bubble decodes the held word while fetch shows junk
    task automatic replay_last(input logic stl);
        row_t r;
        r          = rows[rows.size() - 1];
        r.fetch    = 32'hFFFF_FFFF;
        r.stall    = stl;
        r.hazard   = 1'b0;
        r.rs1_data = $urandom;
        r.rs2_data = $urandom;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(i_type(5, 0, 0, 1, OPC_OP_IMM), 32'h100, 1'b0, ADD, PL_RI, 5, 1'b0, 1'b0);
        add_row(r_type(0, 4, 2, 0, 3), 32'h104, 1'b0, ADD, PL_RR, 0, 1'b0, 1'b0);
        add_row(r_type(32, 7, 6, 0, 5), 32'h108, 1'b0, SUB, PL_RR, 0, 1'b0, 1'b0);
        add_row(i_type(3, 9, 1, 8, OPC_OP_IMM), 32'h10C, 1'b0, SLL, PL_RI, 3, 1'b0, 1'b0);
        add_row(i_type(32'h404, 11, 5, 10, OPC_OP_IMM), 32'h110, 1'b0, SRA, PL_RI, 32'h404,
                1'b0, 1'b0);                                           // srai x10, x11, 4
        add_row(u_type(32'h12345, 12, OPC_LUI), 32'h114, 1'b0, LUI, PL_PC, 32'h1234_5000,
                1'b0, 1'b0);
        add_row(u_type(32'hFFFFF, 13, OPC_AUIPC), 32'h118, 1'b0, ADD, PL_PC, 32'hFFFF_F000,
                1'b0, 1'b0);
        add_row(j_type(-8, 1), 32'h11C, 1'b0, JAL, PL_PC, -8, 1'b0, 1'b0);
        add_row(i_type(12, 15, 0, 14, OPC_JALR), 32'h120, 1'b0, JALR, PL_RI, 12, 1'b0, 1'b0);
        add_row(b_type(-16, 17, 16, 0), 32'h124, 1'b0, BEQ, PL_RR, -16, 1'b0, 1'b0);
        add_row(b_type(8, 19, 18, 6), 32'h128, 1'b0, BLTU, PL_RR, 8, 1'b0, 1'b0);
        add_row(i_type(-4, 21, 2, 20, OPC_LOAD), 32'h12C, 1'b0, LW, PL_RI, -4, 1'b0, 1'b0);
        add_row(i_type(7, 23, 4, 22, OPC_LOAD), 32'h130, 1'b0, LBU, PL_RI, 7, 1'b0, 1'b0);
        add_row(s_type(16, 24, 25, 2), 32'h134, 1'b0, SW, PL_ST, 16, 1'b0, 1'b0);
        // Load behind store
        add_row(i_type(0, 27, 1, 26, OPC_LOAD), 32'h138, 1'b0, LH, PL_RI, 0, 1'b1, 1'b0);
        replay_last(1'b0);
        add_row(r_type(0, 3, 26, 0, 28), 32'h13C, 1'b0, ADD, PL_RR, 0, 1'b1, 1'b0);  // RAW on rs1
        replay_last(1'b0);
        add_row(s_type(4, 28, 2, 1), 32'h140, 1'b0, SH, PL_ST, 4, 1'b1, 1'b0);       // RAW on rs2
        replay_last(1'b0);
        // x0 destination then x0 reads without a lock
        add_row(i_type(1, 5, 0, 0, OPC_OP_IMM), 32'h144, 1'b0, ADD, PL_RI, 1, 1'b0, 1'b0);
        add_row(r_type(0, 0, 0, 0, 6), 32'h148, 1'b0, ADD, PL_RR, 0, 1'b0, 1'b0);
        add_row(32'h0000_0073, 32'h14C, 1'b0, INVALID, PL_RR, 0, 1'b0, 1'b1);          // ecall
        add_row(i_type(1, 8, 0, 7, OPC_OP_IMM), 32'h202, 1'b0, ADD, PL_RI, 1, 1'b0, 1'b0);
        // Two stalled rows hold the outputs
        add_row(r_type(0, 11, 10, 6, 9), 32'h204, 1'b1, OR, PL_RR, 0, 1'b0, 1'b0);
        add_row(r_type(0, 14, 13, 4, 12), 32'h204, 1'b1, XOR, PL_RR, 0, 1'b0, 1'b0);
        add_row(r_type(0, 17, 16, 7, 15), 32'h204, 1'b0, AND, PL_RR, 0, 1'b0, 1'b0);
        add_row(r_type(0, 1, 15, 6, 18), 32'h208, 1'b1, OR, PL_RR, 0, 1'b1, 1'b0);  // Beats stall
        replay_last(1'b0);
        add_row(32'h0FF0_000F, 32'h20C, 1'b0, NOP, PL_RR, 0, 1'b0, 1'b0);             // fence
        add_row(i_type(-1, 18, 2, 19, OPC_OP_IMM), 32'h210, 1'b0, SLT, PL_RI, -1, 1'b0, 1'b0);
        add_row(b_type(20, 0, 19, 5), 32'h214, 1'b0, BGE, PL_RR, 20, 1'b1, 1'b0);
        replay_last(1'b0);
        add_row(i_type(0, 0, 0, 0, OPC_OP_IMM), 32'h218, 1'b0, ADD, PL_RI, 0, 1'b0, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // Expected values and checks
    //////////////////////////////////////////////////

    task automatic check_value(input string field, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s in row %0d is %h, expected %h",
                     $time, field, cur_row, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Registered outputs after the edge that took row r
    task automatic update_model(input row_t r);
        if (r.hazard || !r.stall) begin
            exp_rd  = lock_rd;
            lock_rd = r.hazard ? 5'd0 : r.instr[11:7];
        end
        if (r.hazard) begin            // Bubble
            exp_op  = NOP;
            exp_op1 = '0;
            exp_op2 = '0;
            exp_op3 = '0;
            exp_pc  = '0;
            exp_ill = 1'b0;
            exp_mis = 1'b0;
        end else if (!r.stall) begin
            exp_op = r.op;
            case (r.place)
                PL_PC: begin
                    exp_op1 = r.pc;
                    exp_op2 = r.imm;
                    exp_op3 = r.imm;
                end
                PL_RR: begin
                    exp_op1 = r.rs1_data;
                    exp_op2 = r.rs2_data;
                    exp_op3 = r.imm;
                end
                PL_ST: begin
                    exp_op1 = r.rs1_data;
                    exp_op2 = r.imm;
                    exp_op3 = r.rs2_data;
                end
                default: begin
                    exp_op1 = r.rs1_data;
                    exp_op2 = r.imm;
                    exp_op3 = r.imm;
                end
            endcase
            exp_pc  = r.pc;
            exp_ill = r.illegal;
            exp_mis = r.misaligned;
        end
    endtask

    task automatic check_registered();
        check_value("op_o", 32'(op), 32'(exp_op));
        check_value("op1_o", op1, exp_op1);
        check_value("op2_o", op2, exp_op2);
        check_value("op3_o", op3, exp_op3);
        check_value("pc_o", pc_out, exp_pc);
        check_value("exc_illegal_o", 32'(exc_illegal), 32'(exp_ill));
        check_value("exc_misaligned_o", 32'(exc_misaligned), 32'(exp_mis));
        check_value("rd_o", 32'(rd), 32'(exp_rd));
    endtask

    // Same-cycle outputs
    task automatic check_comb(input row_t r);
        check_value("hazard_o", 32'(hazard), 32'(r.hazard));
        check_value("rs1_o", 32'(rs1), 32'(r.instr[19:15]));
        check_value("rs2_o", 32'(rs2), 32'(r.instr[24:20]));
    endtask

    task automatic apply_row(input row_t r);
        instr    = r.fetch;
        pc       = r.pc;
        stall    = r.stall;
        rs1_data = r.rs1_data;
        rs2_data = r.rs2_data;
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        reset    = 1'b1;
        stall    = 1'b0;
        instr    = 32'h0000_0013;   // addi x0, x0, 0
        pc       = '0;
        rs1_data = '0;
        rs2_data = '0;
        exp_op   = NOP;
        {exp_op1, exp_op2, exp_op3, exp_pc} = '0;
        {exp_ill, exp_mis} = 2'b00;
        exp_rd   = '0;
        lock_rd  = '0;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(SEED));
        build_table();
        built = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_registered();          // Reset state
        #1;
        reset = 1'b0;
        foreach (rows[k]) begin
            cur_row = k;
            apply_row(rows[k]);      // 2 ns after the edge
            #8;
            check_comb(rows[k]);
            @(posedge clk);
            update_model(rows[k]);
            #1;
            check_registered();
            #1;
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        wait (built);
        #((rows.size() + RESET_CYCLES + 20) * PERIOD);
        $display("Watchdog expired before the table was done");
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    end

endmodule

/* sim.f */
+incdir+.
decode_pkg.sv
dec_info_if.sv
op_decoder.sv
imm_gen.sv
hazard_ctrl.sv
operand_stage.sv
decode_stage.sv
tb_decode_stage.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_decode_stage
FILELIST = sim.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) decode_defs.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
